// File: source/isa_pkg.sv
`default_nettype none

// opcode, register and read-count definitions for the 16-bit core.
package isa_pkg;

	typedef logic [4:0] opcode_t;      // instr[15:11].
	typedef logic [2:0] reg_idx_t;     // register number.
	typedef logic [1:0] read_count_t;  // 0, 1 or 2 sources.

	localparam int num_regs = 8;            // architectural registers.
	localparam reg_idx_t link_reg = 3'd7;   // return address for jal/jalr.

	// control and jumps.
	localparam opcode_t op_halt = 5'b00000;
	localparam opcode_t op_nop  = 5'b00001;
	localparam opcode_t op_j    = 5'b00100;
	localparam opcode_t op_jr   = 5'b00101;
	localparam opcode_t op_jal  = 5'b00110;
	localparam opcode_t op_jalr = 5'b00111;

	// immediate alu, rd in bits 7:5.
	localparam opcode_t op_addi  = 5'b01000;
	localparam opcode_t op_subi  = 5'b01001;
	localparam opcode_t op_xori  = 5'b01010;
	localparam opcode_t op_andni = 5'b01011;
	localparam opcode_t op_roli  = 5'b10100;
	localparam opcode_t op_slli  = 5'b10101;
	localparam opcode_t op_rori  = 5'b10110;
	localparam opcode_t op_srli  = 5'b10111;

	// branches, test rs only.
	localparam opcode_t op_beqz = 5'b01100;
	localparam opcode_t op_bnez = 5'b01101;
	localparam opcode_t op_bltz = 5'b01110;
	localparam opcode_t op_bgez = 5'b01111;

	// memory and immediate loads.
	localparam opcode_t op_st   = 5'b10000;
	localparam opcode_t op_ld   = 5'b10001;
	localparam opcode_t op_slbi = 5'b10010;
	localparam opcode_t op_stu  = 5'b10011;
	localparam opcode_t op_lbi  = 5'b11000;
	localparam opcode_t op_btr  = 5'b11001;

	// register-register formats, rd in bits 4:2.
	localparam opcode_t op_alu_shift = 5'b11010;  // rol, sll, ror, srl.
	localparam opcode_t op_alu_arith = 5'b11011;  // add, sub, xor, andn.
	localparam opcode_t op_seq = 5'b11100;
	localparam opcode_t op_slt = 5'b11101;
	localparam opcode_t op_sle = 5'b11110;
	localparam opcode_t op_sco = 5'b11111;

endpackage

`default_nettype wire

// File: source/reg_read_count.sv
`default_nettype none

// number of source registers an instruction reads.
module reg_read_count (
	input wire [15:0] instr,
	output isa_pkg::read_count_t num
);
	import isa_pkg::*;

	opcode_t opcode;

	assign opcode = instr[15:11];

	always_comb begin
		case (opcode)
			// no register sources.
			op_halt,
			op_nop,
			op_j,
			op_jal,
			op_lbi: begin
				num = 2'd0;
			end
			// rs only.
			op_addi,
			op_subi,
			op_xori,
			op_andni,
			op_roli,
			op_slli,
			op_rori,
			op_srli: begin
				num = 2'd1;  // immediate alu.
			end
			op_ld,
			op_slbi: begin
				num = 2'd1;  // address base or shifted rs.
			end
			op_jr,
			op_jalr: begin
				num = 2'd1;  // jump target base.
			end
			op_beqz,
			op_bnez,
			op_bltz,
			op_bgez,
			op_btr: begin
				num = 2'd1;  // branch test or bit reverse.
			end
			// rs and rt.
			op_st,
			op_stu: begin
				num = 2'd2;  // base plus store data.
			end
			op_alu_arith,
			op_alu_shift: begin
				num = 2'd2;
			end
			op_seq,
			op_slt,
			op_sle,
			op_sco: begin
				num = 2'd2;  // compare formats.
			end
			default: begin
				num = 2'd0;  // unknown opcode reads nothing.
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/reg_dest_decode.sv
`default_nettype none

// destination register and write flag by opcode class.
module reg_dest_decode (
	input wire [15:0] instr,
	output isa_pkg::reg_idx_t dest,
	output logic writes
);
	import isa_pkg::*;

	opcode_t opcode;
	reg_idx_t fld_hi;   // bits 10:8.
	reg_idx_t fld_mid;  // bits 7:5.
	reg_idx_t fld_lo;   // bits 4:2.

	assign opcode = instr[15:11];
	assign fld_hi = instr[10:8];
	assign fld_mid = instr[7:5];
	assign fld_lo = instr[4:2];

	always_comb begin
		dest = '0;     // don't care when writes is low.
		writes = 1'b0;
		case (opcode)
			// i-format, rd in the middle field.
			op_addi,
			op_subi,
			op_xori,
			op_andni,
			op_roli,
			op_slli,
			op_rori,
			op_srli,
			op_ld: begin
				dest = fld_mid;
				writes = 1'b1;
			end
			// rs is also the target here.
			op_stu,
			op_lbi,
			op_slbi: begin
				dest = fld_hi;
				writes = 1'b1;
			end
			// r-format, rd in the low field.
			op_btr,
			op_alu_arith,
			op_alu_shift,
			op_seq,
			op_slt,
			op_sle,
			op_sco: begin
				dest = fld_lo;
				writes = 1'b1;
			end
			// link writes pc+2 into r7.
			op_jal,
			op_jalr: begin
				dest = link_reg;
				writes = 1'b1;
			end
			default: begin
				// stores, branches, jumps, halt, nop.
				dest = '0;
				writes = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/reg_file.sv
`default_nettype none

// eight registers, two async reads, one sync write.
module reg_file #(
	parameter int data_width = 16
) (
	input wire clk,
	input wire rst,
	input wire isa_pkg::reg_idx_t rd_addr_a,
	input wire isa_pkg::reg_idx_t rd_addr_b,
	input wire wr_en,
	input wire isa_pkg::reg_idx_t wr_addr,
	input wire [data_width-1:0] wr_data,
	output logic [data_width-1:0] rd_data_a,
	output logic [data_width-1:0] rd_data_b
);
	import isa_pkg::*;

	logic [data_width-1:0] regs [num_regs];
	logic hit_a;  // port a reads the register being written.
	logic hit_b;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;  // all registers start at zero.
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign hit_a = wr_en && (wr_addr == rd_addr_a);
	assign hit_b = wr_en && (wr_addr == rd_addr_b);

	// bypass so a same-cycle write-back is seen by the reader.
	assign rd_data_a = hit_a ? wr_data : regs[rd_addr_a];
	assign rd_data_b = hit_b ? wr_data : regs[rd_addr_b];

endmodule

`default_nettype wire

// File: source/scoreboard.sv
`default_nettype none

// one pending bit per register, raw and waw stall.
module scoreboard (
	input wire clk,
	input wire rst,
	input wire isa_pkg::read_count_t num,
	input wire isa_pkg::reg_idx_t src_a,
	input wire isa_pkg::reg_idx_t src_b,
	input wire isa_pkg::reg_idx_t dest,
	input wire writes,
	input wire want,    // instruction waiting at the input.
	input wire issue,   // accepted this edge.
	input wire clear_en,
	input wire isa_pkg::reg_idx_t clear_reg,
	output logic stall
);
	import isa_pkg::*;

	logic [num_regs-1:0] pending;
	logic [num_regs-1:0] clear_mask;
	logic [num_regs-1:0] set_mask;
	logic [num_regs-1:0] live;   // pending minus this cycle's write-back.
	logic raw_a;
	logic raw_b;
	logic waw;

	always_comb begin
		clear_mask = '0;
		if (clear_en) clear_mask[clear_reg] = 1'b1;
	end

	// issue depends on stall, so the set side stays apart from the clear side.
	always_comb begin
		set_mask = '0;
		if (issue && writes) set_mask[dest] = 1'b1;
	end

	assign live = pending & ~clear_mask;

	// rs checked for 1 or 2 reads, rt only for 2.
	assign raw_a = (num != 2'd0) && live[src_a];
	assign raw_b = (num == 2'd2) && live[src_b];
	assign waw = writes && live[dest];

	assign stall = want && (raw_a || raw_b || waw);

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
		end else begin
			pending <= (pending & ~clear_mask) | set_mask;  // set wins.
		end
	end

endmodule

`default_nettype wire

// File: source/decode_issue.sv
`default_nettype none

// decode and issue stage with scoreboard and register file.
module decode_issue #(
	parameter int data_width = 16
) (
	input wire clk,
	input wire rst,
	input wire instr_valid,
	input wire [15:0] instr,
	input wire wb_en,
	input wire isa_pkg::reg_idx_t wb_reg,
	input wire [data_width-1:0] wb_data,
	output logic stall,
	output logic issue_valid,
	output logic [15:0] issue_instr,
	output logic [data_width-1:0] src1_data,
	output logic [data_width-1:0] src2_data
);
	import isa_pkg::*;

	read_count_t num_reads;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t dest;
	logic writes;
	logic issue;
	logic [data_width-1:0] rd_data_a;
	logic [data_width-1:0] rd_data_b;
	logic [data_width-1:0] src1_next;
	logic [data_width-1:0] src2_next;

	assign rs = instr[10:8];
	assign rt = instr[7:5];

	reg_read_count u_read_count (
		.instr (instr),
		.num   (num_reads)
	);

	reg_dest_decode u_dest_decode (
		.instr  (instr),
		.dest   (dest),
		.writes (writes)
	);

	reg_file #(
		.data_width (data_width)
	) u_reg_file (
		.clk       (clk),
		.rst       (rst),
		.rd_addr_a (rs),
		.rd_addr_b (rt),
		.wr_en     (wb_en),
		.wr_addr   (wb_reg),
		.wr_data   (wb_data),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	scoreboard u_scoreboard (
		.clk       (clk),
		.rst       (rst),
		.num       (num_reads),
		.src_a     (rs),
		.src_b     (rt),
		.dest      (dest),
		.writes    (writes),
		.want      (instr_valid),
		.issue     (issue),
		.clear_en  (wb_en),
		.clear_reg (wb_reg),
		.stall     (stall)
	);

	assign issue = instr_valid && !stall;  // accept this edge.

	// unread sources go out as zero.
	assign src1_next = (num_reads != 2'd0) ? rd_data_a : '0;
	assign src2_next = (num_reads == 2'd2) ? rd_data_b : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= issue;  // one cycle per accept.
		end
	end

	// payload only loads on accept.
	always_ff @(posedge clk) begin
		if (issue) begin
			issue_instr <= instr;
			src1_data <= src1_next;
			src2_data <= src2_next;
		end
	end

endmodule

`default_nettype wire

// File: testbench/decode_issue_properties.sv
`default_nettype none

// handshake rules of the issue stage.
module decode_issue_properties (
	input wire clk,
	input wire rst,
	input wire instr_valid,
	input wire stall,
	input wire issue_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	// a stalled edge accepts nothing.
	no_issue_after_stall: assert property (@(posedge clk) disable iff (rst)
		stall |=> !issue_valid)
		else $error("issue_valid high after a stalled cycle");

	stall_needs_valid: assert property (@(posedge clk) disable iff (rst)
		!instr_valid |-> !stall)
		else $error("stall high with no instruction waiting");

	// no input, no issue one cycle later.
	issue_needs_valid: assert property (@(posedge clk) disable iff (rst)
		!instr_valid |=> !issue_valid)
		else $error("issue_valid high without an accepted instruction");

endmodule

bind decode_issue decode_issue_properties props (
	.clk         (clk),
	.rst         (rst),
	.instr_valid (instr_valid),
	.stall       (stall),
	.issue_valid (issue_valid)
);

`default_nettype wire

// File: testbench/tb_clock.sv
`default_nettype none

// free-running clock and power-on reset.
module tb_clock (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // 100 ns period.
	end

	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);  // four edges in reset.
		@(negedge clk);
		rst = 1'b0;  // released away from the rising edge.
	end

endmodule

`default_nettype wire

// File: testbench/decode_issue_tb.sv
`default_nettype none

// testbench for the decode and issue stage.
module decode_issue_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import isa_pkg::*;

	localparam int data_width = 16;
	localparam int stim_cycles = 100 + 300;  // directed tests plus random stream.
	localparam int cycle_limit = 10 * stim_cycles;
	localparam opcode_t no_write_ops [4] = '{op_st, op_beqz, op_j, op_jr};

	typedef struct packed {
		read_count_t num;
		reg_idx_t dest;
		logic writes;
	} dec_t;

	logic clk;
	logic rst;
	logic instr_valid;
	logic [15:0] instr;
	logic wb_en;
	reg_idx_t wb_reg;
	logic [data_width-1:0] wb_data;
	logic stall;
	logic issue_valid;
	logic [15:0] issue_instr;
	logic [data_width-1:0] src1_data;
	logic [data_width-1:0] src2_data;

	logic [data_width-1:0] model_regs [8];  // register values as the model sees them.
	logic [7:0] model_pend;
	logic [47:0] exp_q [$];  // {instr, src1, src2} per accept.
	int next_issue = 0;      // read index, owned by the compare process.
	logic stall_seen = 1'b0; // stall in the cycle before the last edge.
	string cur_test = "reset";
	int errors = 0;
	int checks = 0;
	int cmp_errors = 0;
	int cmp_checks = 0;
	int err_start = 0;
	int tests_ok = 0;
	int tests_run = 0;
	int cycle_count = 0;

	tb_clock clock_gen (
		.clk (clk),
		.rst (rst)
	);

	decode_issue #(
		.data_width (data_width)
	) uut (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_en       (wb_en),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data),
		.stall       (stall),
		.issue_valid (issue_valid),
		.issue_instr (issue_instr),
		.src1_data   (src1_data),
		.src2_data   (src2_data)
	);

	// read count, destination and write flag from the opcode tables.
	function automatic dec_t ref_decode(input logic [15:0] ins);
		dec_t d;
		case (ins[15:11])
			op_addi, op_subi, op_xori, op_andni, op_roli, op_slli, op_rori, op_srli, op_ld:
				d = '{2'd1, ins[7:5], 1'b1};
			op_slbi: d = '{2'd1, ins[10:8], 1'b1};
			op_jr, op_beqz, op_bnez, op_bltz, op_bgez: d = '{2'd1, 3'd0, 1'b0};
			op_jalr: d = '{2'd1, link_reg, 1'b1};
			op_btr: d = '{2'd1, ins[4:2], 1'b1};
			op_st: d = '{2'd2, 3'd0, 1'b0};
			op_stu: d = '{2'd2, ins[10:8], 1'b1};
			op_alu_arith, op_alu_shift, op_seq, op_slt, op_sle, op_sco:
				d = '{2'd2, ins[4:2], 1'b1};
			op_jal: d = '{2'd0, link_reg, 1'b1};
			op_lbi: d = '{2'd0, ins[10:8], 1'b1};
			default: d = '{2'd0, 3'd0, 1'b0};  // halt, nop, j, unknown.
		endcase
		return d;
	endfunction

	// operand as read at the edge, write-back bypassed.
	function automatic logic [15:0] src_value(input logic used, input reg_idx_t r,
			input logic we, input reg_idx_t wr, input logic [15:0] wd);
		if (!used) return '0;
		if (we && wr == r) return wd;
		return model_regs[r];
	endfunction

	function automatic logic [15:0] mk(input opcode_t op, input reg_idx_t a,
			input reg_idx_t b, input reg_idx_t c);
		return {op, a, b, c, 2'b00};
	endfunction

	// one clock of stimulus; the model predicts stall and follows the edge.
	task automatic step(input logic v, input logic [15:0] ins, input logic we,
			input reg_idx_t wr, input logic [15:0] wd, output logic acc);
		dec_t d;
		logic [7:0] live;
		logic exp_stall;
		logic [15:0] s1;
		logic [15:0] s2;
		@(negedge clk);
		instr_valid = v;
		instr = ins;
		wb_en = we;
		wb_reg = wr;
		wb_data = wd;
		#10;
		d = ref_decode(ins);
		live = model_pend;
		if (we) live[wr] = 1'b0;  // write-back this cycle is not a hazard.
		exp_stall = v && ((d.num != 2'd0 && live[ins[10:8]]) ||
			(d.num == 2'd2 && live[ins[7:5]]) || (d.writes && live[d.dest]));
		checks++;
		if (stall !== exp_stall) begin
			errors++;
			$display("** Error %s: stall expected %b, actual %b", cur_test, exp_stall, stall);
		end
		stall_seen = stall;
		acc = v && !exp_stall;
		if (acc) begin
			s1 = src_value(d.num != 2'd0, ins[10:8], we, wr, wd);
			s2 = src_value(d.num == 2'd2, ins[7:5], we, wr, wd);
			exp_q.push_back({ins, s1, s2});
		end
		if (we) begin
			model_regs[wr] = wd;
			model_pend[wr] = 1'b0;
		end
		if (acc && d.writes) model_pend[d.dest] = 1'b1;  // set after clear.
	endtask

	// hold an instruction until accepted.
	task automatic offer(input logic [15:0] ins);
		logic acc;
		int n;
		acc = 1'b0;
		n = 0;
		while (!acc && n < 20) begin
			step(1'b1, ins, 1'b0, 3'd0, 16'd0, acc);
			n++;
		end
		if (!acc) begin
			errors++;
			$display("%s: instruction %h was never accepted", cur_test, ins);
		end
	endtask

	// write back every pending register, then let issues drain.
	task automatic flush();
		logic acc;
		reg_idx_t r;
		for (int i = 0; i < num_regs; i++) begin
			r = 3'(i);
			if (model_pend[r]) step(1'b0, 16'd0, 1'b1, r, 16'($urandom), acc);
		end
		repeat (2) step(1'b0, 16'd0, 1'b0, 3'd0, 16'd0, acc);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_start = errors + cmp_errors;
	endtask

	task automatic finish_test();
		flush();
		if (exp_q.size() != next_issue) begin
			errors++;
			$display("%s: %0d accepted instructions never issued", cur_test,
				exp_q.size() - next_issue);
		end
		tests_run++;
		if (errors + cmp_errors == err_start) begin
			tests_ok++;
			$display("%s: ok", cur_test);
		end else begin
			$display("%s: %0d errors", cur_test, errors + cmp_errors - err_start);
		end
	endtask

	// each issue against the oldest accepted instruction.
	always @(negedge clk) begin
		if (!rst && issue_valid) begin
			cmp_checks++;
			if (stall_seen) begin
				cmp_errors++;
				$display("%s: issue_valid followed a stalled cycle", cur_test);
			end
			if (next_issue >= exp_q.size()) begin
				cmp_errors++;
				$display("%s: issue with no accepted instruction waiting", cur_test);
			end else begin
				if (issue_instr !== exp_q[next_issue][47:32]) begin
					cmp_errors++;
					$display("** Error %s: issue_instr expected %h, actual %h", cur_test,
						exp_q[next_issue][47:32], issue_instr);
				end
				if (src1_data !== exp_q[next_issue][31:16]) begin
					cmp_errors++;
					$display("** Error %s: src1_data expected %h, actual %h", cur_test,
						exp_q[next_issue][31:16], src1_data);
				end
				if (src2_data !== exp_q[next_issue][15:0]) begin
					cmp_errors++;
					$display("** Error %s: src2_data expected %h, actual %h", cur_test,
						exp_q[next_issue][15:0], src2_data);
				end
				next_issue++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run went past %0d cycles", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		logic acc;
		logic [15:0] cur;
		reg_idx_t wr;
		int n_acc;
		int issues_before;
		instr_valid = 1'b0;
		instr = 16'd0;
		wb_en = 1'b0;
		wb_reg = 3'd0;
		wb_data = 16'd0;
		model_pend = '0;
		for (int i = 0; i < num_regs; i++) model_regs[i] = '0;
		void'($urandom(2356));
		@(posedge clk);
		while (rst) @(posedge clk);

		start_test("test 1 reset and zero reads");
		@(negedge clk);  // outputs settled after the first free edge.
		checks++;
		if (stall !== 1'b0) begin
			errors++;
			$display("** Error %s: stall expected 0, actual %b", cur_test, stall);
		end
		checks++;
		if (issue_valid !== 1'b0) begin
			errors++;
			$display("** Error %s: issue_valid expected 0, actual %b", cur_test,
				issue_valid);
		end
		for (int i = 0; i < num_regs; i += 2) offer(mk(op_st, 3'(i), 3'(i + 1), 3'd0));
		finish_test();

		start_test("test 2 write-back values");
		repeat (12) begin
			wr = 3'($urandom);
			step(1'b0, 16'd0, 1'b1, wr, 16'($urandom), acc);
			// rs names the register just written.
			cur = mk(no_write_ops[2'($urandom)], wr, 3'($urandom), 3'($urandom));
			offer(cur);
		end
		finish_test();

		start_test("test 3 read after write");
		offer(mk(op_addi, 3'd1, 3'd3, 3'd0));  // r3 pending.
		cur = mk(op_beqz, 3'd3, 3'd0, 3'd0);
		repeat (3) step(1'b1, cur, 1'b0, 3'd0, 16'd0, acc);
		step(1'b1, cur, 1'b1, 3'd3, 16'($urandom), acc);  // strobe releases it.
		finish_test();

		start_test("test 4 write after write");
		offer(mk(op_ld, 3'd0, 3'd4, 3'd0));
		cur = mk(op_lbi, 3'd4, 3'd2, 3'd1);  // same destination r4.
		repeat (3) step(1'b1, cur, 1'b0, 3'd0, 16'd0, acc);
		step(1'b1, cur, 1'b1, 3'd4, 16'($urandom), acc);
		flush();
		for (int i = 0; i < num_regs; i++) offer(mk(op_lbi, 3'(i), 3'($urandom), 3'd0));
		repeat (3) begin
			cur = mk(op_j, 3'($urandom), 3'($urandom), 3'($urandom));
			step(1'b1, cur, 1'b0, 3'd0, 16'd0, acc);  // all eight pending.
		end
		finish_test();

		start_test("test 5 same-cycle write-back");
		offer(mk(op_lbi, 3'd5, 3'd0, 3'd0));
		step(1'b1, mk(op_sco, 3'd2, 3'd5, 3'd6), 1'b1, 3'd5, 16'($urandom), acc);
		offer(mk(op_lbi, 3'd1, 3'd0, 3'd0));
		step(1'b1, mk(op_slt, 3'd1, 3'd2, 3'd3), 1'b1, 3'd1, 16'($urandom), acc);
		finish_test();

		start_test("test 6 random stream");
		issues_before = next_issue;
		n_acc = 0;
		cur = 16'($urandom);
		repeat (300) begin
			step(1'b1, cur, 1'($urandom), 3'($urandom), 16'($urandom), acc);
			if (acc) begin
				n_acc++;
				cur = 16'($urandom);
			end
		end
		flush();
		checks++;
		if (next_issue - issues_before != n_acc) begin
			errors++;
			$display("** Error %s: issue count expected %0d, actual %0d", cur_test, n_acc,
				next_issue - issues_before);
		end
		finish_test();

		$display("%0d of %0d tests ok, %0d checks, %0d errors", tests_ok, tests_run,
			checks + cmp_checks, errors + cmp_errors);
		if (errors + cmp_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: decode_issue.f
source/isa_pkg.sv
source/reg_read_count.sv
source/reg_dest_decode.sv
source/reg_file.sv
source/scoreboard.sv
source/decode_issue.sv
testbench/decode_issue_properties.sv
testbench/tb_clock.sv
testbench/decode_issue_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f decode_issue.f --top-module decode_issue_tb -o decode_issue_sim
./obj_dir/decode_issue_sim +verilator+error+limit+100 | tee sim.log
if grep -qx "Testbench passed" sim.log; then
	echo "simulation result: pass"
else
	echo "simulation result: fail"
	exit 1
fi
